//--- compile.f
+incdir+src
src/cpuAluPkg.sv
src/aluLaneIf.sv
src/aluArith.sv
src/aluLogicShift.sv
src/aluCommit.sv
src/aluTop.sv
verif/aluClkGen.sv
verif/aluTb.sv

//--- run.sh
#!/bin/sh
# build the ALU testbench with Verilator, run it, and grade the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module aluTb \
	-f compile.f -o aluSim > build.log 2>&1 \
	&& ./obj_dir/aluSim > sim.log 2>&1 \
	|| echo "build or simulation error, see build.log and sim.log"
grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verif/aluTb.sv
// ALU testbench
// directed table of opcodes with hand-worked results and flags,
// LFSR-driven back-to-back operations against a flag-tracking model,
// typed compare tasks, cycle timeout and error summary

`include "cpuAlu_consts.svh"

`default_nettype none

module aluTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int W = `ALU_BITS;
	localparam int NUM_ROWS = 41;
	localparam int NUM_RANDOM = 200;
	localparam int CYCLE_LIMIT = 2 * (NUM_ROWS + NUM_RANDOM) + 50;
	localparam int SMAX = (1 << (W - 1)) - 1;
	localparam int SMIN = -(1 << (W - 1));

	typedef struct packed {
		logic [`ALU_OP_BITS-1:0] op;
		cpuAluPkg::aluDataT a;
		cpuAluPkg::aluDataT b;
		logic exe;	// execute strobe for this row
		cpuAluPkg::aluDataT res;
		cpuAluPkg::aluFlagsT flags;	// {c, z, s, v}
	} rowT;

	typedef struct packed {
		cpuAluPkg::aluDataT res;
		cpuAluPkg::aluFlagsT flags;
	} outcomeT;

	logic CLK;
	logic RSTb;
	cpuAluPkg::aluDataT A;
	cpuAluPkg::aluDataT B;
	logic [`ALU_OP_BITS-1:0] aluOp;
	logic execute;
	cpuAluPkg::aluDataT aluOut;
	logic C;
	logic Z;
	logic S;
	logic V;

	int dataErrors = 0;
	int flagErrors = 0;
	int cycleCount;
	logic [15:0] lfsrState;

	// each row sees the flags left by the row before it
	rowT rows [NUM_ROWS] = '{
		'{cpuAluPkg::opAdd, 16'hFFFF, 16'h0001, 1'b1, 16'h0000, 4'b1100},
		'{cpuAluPkg::opAdd, 16'h7FFF, 16'h0001, 1'b1, 16'h8000, 4'b0011},	// add ignores C
		'{cpuAluPkg::opAdc, 16'hFFFF, 16'h0001, 1'b1, 16'h0000, 4'b1100},	// C was 0
		'{cpuAluPkg::opAdc, 16'h7FFF, 16'h0000, 1'b1, 16'h8000, 4'b0011},	// C was 1
		'{cpuAluPkg::opAdc, 16'h0001, 16'h0002, 1'b1, 16'h0003, 4'b0000},
		'{cpuAluPkg::opSub, 16'h0000, 16'h0001, 1'b1, 16'hFFFF, 4'b1010},
		'{cpuAluPkg::opSub, 16'h0005, 16'h0002, 1'b1, 16'h0003, 4'b0000},	// sub ignores C
		'{cpuAluPkg::opSbb, 16'h8000, 16'h0001, 1'b1, 16'h7FFF, 4'b0001},
		'{cpuAluPkg::opStc, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b1001},
		'{cpuAluPkg::opSbb, 16'h8000, 16'h0000, 1'b1, 16'h7FFF, 4'b0001},	// V from sbb diff
		'{cpuAluPkg::opCmp, 16'h0003, 16'h0003, 1'b1, 16'h0003, 4'b0101},
		'{cpuAluPkg::opCmp, 16'h0000, 16'h0001, 1'b1, 16'h0000, 4'b1011},
		'{cpuAluPkg::opMul, 16'h1234, 16'h0100, 1'b1, 16'h3400, 4'b0001},
		'{cpuAluPkg::opMulu, 16'hFFFF, 16'hFFFF, 1'b1, 16'hFFFE, 4'b0011},
		'{cpuAluPkg::opAnd, 16'hF0F0, 16'h0FF0, 1'b1, 16'h00F0, 4'b0001},
		'{cpuAluPkg::opOr, 16'h8000, 16'h0001, 1'b1, 16'h8001, 4'b0011},
		'{cpuAluPkg::opXor, 16'hAAAA, 16'hAAAA, 1'b1, 16'h0000, 4'b0101},
		'{cpuAluPkg::opXor, 16'h8000, 16'h0001, 1'b1, 16'h8001, 4'b0011},	// S from xor
		'{cpuAluPkg::opStc, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b1011},
		'{cpuAluPkg::opTest, 16'h00FF, 16'hFF00, 1'b1, 16'h00FF, 4'b1111},
		'{cpuAluPkg::opTest, 16'h8001, 16'h0001, 1'b1, 16'h8001, 4'b1011},
		'{cpuAluPkg::opRolc, 16'h0000, 16'h4001, 1'b1, 16'h8003, 4'b0011},
		'{cpuAluPkg::opRorc, 16'h0000, 16'h0003, 1'b1, 16'h0001, 4'b1011},
		'{cpuAluPkg::opRolc, 16'h0000, 16'h0000, 1'b1, 16'h0001, 4'b0011},
		'{cpuAluPkg::opAsr, 16'h0000, 16'h8004, 1'b1, 16'hC002, 4'b0011},
		'{cpuAluPkg::opLsr, 16'h0000, 16'h0001, 1'b1, 16'h0000, 4'b0111},
		'{cpuAluPkg::opLsl, 16'h0000, 16'h4001, 1'b1, 16'h8002, 4'b0011},
		'{cpuAluPkg::opStc, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b1011},
		'{cpuAluPkg::opCls, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b1001},
		'{cpuAluPkg::opStoreFlags, 16'h0000, 16'h0000, 1'b1, 16'h0002, 4'b1001},
		'{cpuAluPkg::opStz, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b1101},
		'{cpuAluPkg::opClc, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b0101},
		'{cpuAluPkg::opClz, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b0001},
		'{cpuAluPkg::opSts, 16'h0000, 16'h0000, 1'b1, 16'h0000, 4'b0011},
		'{cpuAluPkg::opRestoreFlags, 16'h0000, 16'h0006, 1'b1, 16'h0000, 4'b1011},
		'{cpuAluPkg::opStoreFlags, 16'h0000, 16'h0000, 1'b1, 16'h0006, 4'b1011},
		'{5'd10, 16'h1111, 16'h2222, 1'b1, 16'h0000, 4'b1011},	// reserved
		'{5'd31, 16'hFFFF, 16'hFFFF, 1'b1, 16'h0000, 4'b1011},
		'{cpuAluPkg::opMove, 16'h0000, 16'hBEEF, 1'b1, 16'hBEEF, 4'b1011},
		'{cpuAluPkg::opAdd, 16'h0001, 16'h0001, 1'b0, 16'hBEEF, 4'b1011},	// idle row
		'{cpuAluPkg::opCmp, 16'h8000, 16'h0001, 1'b1, 16'h8000, 4'b0001}
	};

	aluClkGen aluClkGen_inst (
		.CLK(CLK),
		.RSTb(RSTb)
	);

	aluTop aluTop_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.A(A),
		.B(B),
		.aluOp(aluOp),
		.execute(execute),
		.aluOut(aluOut),
		.C(C),
		.Z(Z),
		.S(S),
		.V(V)
	);

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(input int n, output logic [15:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrStep(lfsrState);
			val = {val[14:0], lfsrState[0]};	// one step per bit
		end
	endtask

	// opcode rules worked in plain integer arithmetic
	function automatic outcomeT predictOp(input logic [`ALU_OP_BITS-1:0] op,
			input cpuAluPkg::aluDataT a, input cpuAluPkg::aluDataT b,
			input cpuAluPkg::aluFlagsT fIn);
		outcomeT o;
		int unsigned wide;
		int sa;
		int sb;
		int sr;
		logic cin;
		logic zsFromRes;
		o.res = '0;
		o.flags = fIn;
		zsFromRes = 1'b0;
		sa = int'($signed(a));
		sb = int'($signed(b));
		cin = (op == cpuAluPkg::opAdc || op == cpuAluPkg::opSbb) ? fIn.c : 1'b0;
		case (op)
			cpuAluPkg::opAdd, cpuAluPkg::opAdc: begin
				wide = 32'(a) + 32'(b) + 32'(cin);
				sr = sa + sb + int'(cin);
				o.res = wide[W-1:0];
				o.flags.c = wide[W];
				o.flags.v = (sr > SMAX) || (sr < SMIN);
				zsFromRes = 1'b1;
			end
			cpuAluPkg::opSub, cpuAluPkg::opSbb, cpuAluPkg::opCmp: begin
				wide = 32'(a) - 32'(b) - 32'(cin);
				sr = sa - sb - int'(cin);
				o.res = (op == cpuAluPkg::opCmp) ? a : wide[W-1:0];
				o.flags.c = (32'(a) < 32'(b) + 32'(cin));	// borrow
				o.flags.z = (wide[W-1:0] == '0);
				o.flags.s = wide[W-1];
				if (op != cpuAluPkg::opCmp) begin
					o.flags.v = (sr > SMAX) || (sr < SMIN);
				end
			end
			cpuAluPkg::opMul, cpuAluPkg::opMulu: begin
				wide = 32'(a) * 32'(b);
				o.res = (op == cpuAluPkg::opMul) ? wide[W-1:0] : wide[2*W-1:W];
				o.flags.c = 1'b0;
				zsFromRes = 1'b1;
			end
			cpuAluPkg::opAnd, cpuAluPkg::opOr, cpuAluPkg::opXor: begin
				if (op == cpuAluPkg::opAnd) o.res = a & b;
				else if (op == cpuAluPkg::opOr) o.res = a | b;
				else o.res = a ^ b;
				o.flags.c = 1'b0;
				zsFromRes = 1'b1;
			end
			cpuAluPkg::opTest: begin
				o.res = a;
				o.flags.z = ((a & b) == '0);
			end
			cpuAluPkg::opAsr, cpuAluPkg::opLsr, cpuAluPkg::opLsl: begin
				if (op == cpuAluPkg::opAsr) o.res = cpuAluPkg::aluDataT'($signed(b) >>> 1);
				else if (op == cpuAluPkg::opLsr) o.res = b >> 1;
				else o.res = b << 1;
				o.flags.z = (o.res == '0);
			end
			cpuAluPkg::opRolc: begin
				o.res = {b[W-2:0], fIn.c};
				o.flags.c = b[W-1];
			end
			cpuAluPkg::opRorc: begin
				o.res = {fIn.c, b[W-1:1]};
				o.flags.c = b[0];
			end
			cpuAluPkg::opClc: o.flags.c = 1'b0;
			cpuAluPkg::opStc: o.flags.c = 1'b1;
			cpuAluPkg::opClz: o.flags.z = 1'b0;
			cpuAluPkg::opStz: o.flags.z = 1'b1;
			cpuAluPkg::opCls: o.flags.s = 1'b0;
			cpuAluPkg::opSts: o.flags.s = 1'b1;
			cpuAluPkg::opStoreFlags: o.res = cpuAluPkg::aluDataT'({fIn.s, fIn.c, fIn.z});
			cpuAluPkg::opRestoreFlags: begin
				o.flags.z = b[0];
				o.flags.c = b[1];
				o.flags.s = b[2];
			end
			cpuAluPkg::opMove: o.res = b;
			default: ;	// reserved, zero result and flags hold
		endcase
		if (zsFromRes) begin
			o.flags.z = (o.res == '0);
			o.flags.s = o.res[W-1];
		end
		return o;
	endfunction

	function automatic cpuAluPkg::aluFlagsT dutFlags();
		cpuAluPkg::aluFlagsT f;
		f.c = C;
		f.z = Z;
		f.s = S;
		f.v = V;
		return f;
	endfunction

	task automatic checkData(input string name, input cpuAluPkg::aluDataT expected,
			input cpuAluPkg::aluDataT actual);
		if (actual !== expected) begin
			dataErrors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlags(input string name, input cpuAluPkg::aluFlagsT expected,
			input cpuAluPkg::aluFlagsT actual);
		if (actual !== expected) begin
			flagErrors++;
			$display("CHECK FAILED %s flags czsv: expected %b, actual %b",
				name, expected, actual);
		end
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [15:0] bits;
		logic [`ALU_OP_BITS-1:0] rOp;
		logic [`ALU_OP_BITS-1:0] lastOp;
		cpuAluPkg::aluDataT rA;
		cpuAluPkg::aluDataT rB;
		cpuAluPkg::aluFlagsT modelFlags;
		outcomeT want;
		outcomeT pending;
		A = '0;
		B = '0;
		aluOp = '0;
		execute = 1'b0;
		lfsrState = 16'd61;
		rOp = '0;
		lastOp = '0;
		want = '0;
		pending = '0;

		@(posedge RSTb);
		@(negedge CLK);
		checkData("after reset", '0, aluOut);
		checkFlags("after reset", '0, dutFlags());

		// row i is driven here and checked on the next pass
		for (int i = 0; i <= NUM_ROWS; i++) begin
			@(posedge CLK);
			if (i < NUM_ROWS) begin
				aluOp <= rows[i].op;
				A <= rows[i].a;
				B <= rows[i].b;
				execute <= rows[i].exe;
			end else begin
				execute <= 1'b0;
			end
			@(negedge CLK);
			if (i > 0) begin
				checkData($sformatf("row %0d op %0d", i - 1, rows[i-1].op),
					rows[i-1].res, aluOut);
				checkFlags($sformatf("row %0d op %0d", i - 1, rows[i-1].op),
					rows[i-1].flags, dutFlags());
			end
		end

		modelFlags = rows[NUM_ROWS-1].flags;
		for (int i = 0; i <= NUM_RANDOM; i++) begin
			@(posedge CLK);
			if (i < NUM_RANDOM) begin
				drawBits(`ALU_OP_BITS, bits);
				rOp = bits[`ALU_OP_BITS-1:0];
				drawBits(W, bits);
				rA = bits;
				drawBits(W, bits);
				rB = bits;
				aluOp <= rOp;
				A <= rA;
				B <= rB;
				execute <= 1'b1;	// strobes back to back
				want = predictOp(rOp, rA, rB, modelFlags);
			end else begin
				execute <= 1'b0;
			end
			@(negedge CLK);
			if (i > 0) begin
				checkData($sformatf("random %0d op %0d", i - 1, lastOp), pending.res, aluOut);
				checkFlags($sformatf("random %0d op %0d", i - 1, lastOp),
					pending.flags, dutFlags());
			end
			pending = want;
			lastOp = rOp;
			modelFlags = want.flags;
		end

		$display("errors: %0d data, %0d flags", dataErrors, flagErrors);
		if (dataErrors + flagErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/aluClkGen.sv
// clock and reset source for the ALU testbench
// 20 ns clock, active-low reset held for two rising edges

`default_nettype none

module aluClkGen (
	output logic CLK,
	output logic RSTb
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;	// 20 ns period
	end

	initial begin
		RSTb = 1'b0;
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;	// released on the edge like other stimulus
	end

endmodule

`default_nettype wire

//--- src/aluTop.sv
// ALU top level
// two execution lanes, the arithmetic and logic/shift units
// and the commit stage behind plain ports

`include "cpuAlu_consts.svh"

`default_nettype none

module aluTop (
	input  logic CLK,
	input  logic RSTb,
	input  cpuAluPkg::aluDataT A,
	input  cpuAluPkg::aluDataT B,
	input  logic [`ALU_OP_BITS-1:0] aluOp,
	input  logic execute,
	output cpuAluPkg::aluDataT aluOut,
	output logic C,	// carry
	output logic Z,	// zero
	output logic S,	// sign
	output logic V	// overflow
);

	aluLaneIf arithLane ();
	aluLaneIf logicLane ();

	aluArith aluArith_inst (
		.lane(arithLane)
	);

	aluLogicShift aluLogicShift_inst (
		.lane(logicLane)
	);

	aluCommit aluCommit_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.execute(execute),
		.A(A),
		.B(B),
		.aluOp(aluOp),
		.arithLane(arithLane),
		.logicLane(logicLane),
		.aluOut(aluOut),
		.C(C),
		.Z(Z),
		.S(S),
		.V(V)
	);

endmodule

`default_nettype wire

//--- src/aluCommit.sv
// commit stage of the ALU
// operand fan-out to both lanes, claim select, result and flag registers,
// lane and register assertions

`include "cpuAlu_consts.svh"

`default_nettype none

module aluCommit (
	input  logic CLK,
	input  logic RSTb,
	input  logic execute,	// one-cycle strobe
	input  cpuAluPkg::aluDataT A,
	input  cpuAluPkg::aluDataT B,
	input  logic [`ALU_OP_BITS-1:0] aluOp,
	aluLaneIf.commit arithLane,
	aluLaneIf.commit logicLane,
	output cpuAluPkg::aluDataT aluOut,
	output logic C,
	output logic Z,
	output logic S,
	output logic V
);

	cpuAluPkg::aluDataT resQ;
	cpuAluPkg::aluDataT resNext;
	cpuAluPkg::aluFlagsT flagsQ;
	cpuAluPkg::aluFlagsT flagsNext;

	assign arithLane.a = A;
	assign arithLane.b = B;
	assign arithLane.op = cpuAluPkg::aluOpE'(aluOp);
	assign arithLane.flagsIn = flagsQ;

	assign logicLane.a = A;
	assign logicLane.b = B;
	assign logicLane.op = cpuAluPkg::aluOpE'(aluOp);
	assign logicLane.flagsIn = flagsQ;

	always_comb begin
		if (arithLane.claim) begin
			resNext = arithLane.res;
			flagsNext = arithLane.flagsNext;
		end else if (logicLane.claim) begin
			resNext = logicLane.res;
			flagsNext = logicLane.flagsNext;
		end else begin
			resNext = '0;	// reserved opcode
			flagsNext = flagsQ;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			resQ <= '0;
			flagsQ <= '0;
		end else if (execute) begin
			resQ <= resNext;
			flagsQ <= flagsNext;
		end
	end

	assign aluOut = resQ;
	assign C = flagsQ.c;
	assign Z = flagsQ.z;
	assign S = flagsQ.s;
	assign V = flagsQ.v;

	// opcode sets of the two units must not overlap
	assert property (@(posedge CLK) disable iff (!RSTb)
		!(arithLane.claim && logicLane.claim));

	assert property (@(posedge CLK) disable iff (!RSTb)
		!execute |=> ($stable(flagsQ) && $stable(resQ)));	// idle cycles hold

	assert property (@(posedge CLK)
		!RSTb |=> ((aluOut == '0) && (flagsQ == '0)));

endmodule

`default_nettype wire

//--- src/aluLogicShift.sv
// logic, shift and flag execution unit
// move, bitwise ops, test, single-bit shifts, rotates through carry,
// flag set/clear, store flags and restore flags

`include "cpuAlu_consts.svh"

`default_nettype none

module aluLogicShift (
	aluLaneIf.unit lane
);

	localparam int W = `ALU_BITS;

	cpuAluPkg::aluDataT andRes;
	cpuAluPkg::aluDataT orRes;
	cpuAluPkg::aluDataT xorRes;
	cpuAluPkg::aluDataT asrRes;
	cpuAluPkg::aluDataT lsrRes;
	cpuAluPkg::aluDataT lslRes;
	cpuAluPkg::aluDataT rolcRes;
	cpuAluPkg::aluDataT rorcRes;
	cpuAluPkg::aluDataT flagWord;

	assign andRes = lane.a & lane.b;
	assign orRes = lane.a | lane.b;
	assign xorRes = lane.a ^ lane.b;

	// shifts and rotates act on B only
	assign asrRes = {lane.b[W-1], lane.b[W-1:1]};	// sign kept
	assign lsrRes = {1'b0, lane.b[W-1:1]};
	assign lslRes = {lane.b[W-2:0], 1'b0};
	assign rolcRes = {lane.b[W-2:0], lane.flagsIn.c};
	assign rorcRes = {lane.flagsIn.c, lane.b[W-1:1]};

	assign flagWord = {{(W-3){1'b0}}, lane.flagsIn.s, lane.flagsIn.c, lane.flagsIn.z};

	always_comb begin
		lane.claim = 1'b1;
		lane.res = '0;	// flag ops output zero
		lane.flagsNext = lane.flagsIn;

		case (lane.op)
			cpuAluPkg::opMove: begin
				lane.res = lane.b;
			end
			cpuAluPkg::opAnd: begin
				lane.res = andRes;
				lane.flagsNext.c = 1'b0;
				lane.flagsNext.z = (andRes == '0);
				lane.flagsNext.s = andRes[W-1];
			end
			cpuAluPkg::opOr: begin
				lane.res = orRes;
				lane.flagsNext.c = 1'b0;
				lane.flagsNext.z = (orRes == '0);
				lane.flagsNext.s = orRes[W-1];
			end
			cpuAluPkg::opXor: begin
				lane.res = xorRes;
				lane.flagsNext.c = 1'b0;
				lane.flagsNext.z = (xorRes == '0);
				lane.flagsNext.s = xorRes[W-1];
			end
			cpuAluPkg::opTest: begin
				lane.res = lane.a;	// only Z changes
				lane.flagsNext.z = (andRes == '0);
			end
			cpuAluPkg::opAsr: begin
				lane.res = asrRes;
				lane.flagsNext.z = (asrRes == '0);
			end
			cpuAluPkg::opLsr: begin
				lane.res = lsrRes;
				lane.flagsNext.z = (lsrRes == '0);
			end
			cpuAluPkg::opLsl: begin
				lane.res = lslRes;
				lane.flagsNext.z = (lslRes == '0);
			end
			cpuAluPkg::opRolc: begin
				lane.res = rolcRes;
				lane.flagsNext.c = lane.b[W-1];	// bit shifted out
			end
			cpuAluPkg::opRorc: begin
				lane.res = rorcRes;
				lane.flagsNext.c = lane.b[0];
			end
			cpuAluPkg::opClc: lane.flagsNext.c = 1'b0;
			cpuAluPkg::opStc: lane.flagsNext.c = 1'b1;
			cpuAluPkg::opClz: lane.flagsNext.z = 1'b0;
			cpuAluPkg::opStz: lane.flagsNext.z = 1'b1;
			cpuAluPkg::opCls: lane.flagsNext.s = 1'b0;
			cpuAluPkg::opSts: lane.flagsNext.s = 1'b1;
			cpuAluPkg::opStoreFlags: begin
				lane.res = flagWord;
			end
			cpuAluPkg::opRestoreFlags: begin
				lane.flagsNext.z = lane.b[0];
				lane.flagsNext.c = lane.b[1];
				lane.flagsNext.s = lane.b[2];
			end
			default: begin
				lane.claim = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/aluArith.sv
// arithmetic execution unit
// add, adc, sub, sbb, cmp, mul and mulu with their flag rules

`include "cpuAlu_consts.svh"

`default_nettype none

module aluArith (
	aluLaneIf.unit lane
);

	localparam int W = `ALU_BITS;

	logic cin;
	logic [W:0] addExt;	// carry in top bit
	logic [W:0] subExt;	// borrow in top bit
	logic [`ALU_PROD_BITS-1:0] prod;
	logic addOvf;
	logic subOvf;
	cpuAluPkg::aluDataT mulLo;
	cpuAluPkg::aluDataT mulHi;

	// only adc and sbb chain the stored carry
	assign cin = ((lane.op == cpuAluPkg::opAdc) || (lane.op == cpuAluPkg::opSbb)) ?
		lane.flagsIn.c : 1'b0;

	assign addExt = {1'b0, lane.a} + {1'b0, lane.b} + {{W{1'b0}}, cin};
	assign subExt = {1'b0, lane.a} - {1'b0, lane.b} - {{W{1'b0}}, cin};

	assign prod = {{W{1'b0}}, lane.a} * {{W{1'b0}}, lane.b};	// unsigned
	assign mulLo = prod[W-1:0];
	assign mulHi = prod[2*W-1:W];

	// same-sign inputs, result sign flipped
	assign addOvf = (lane.a[W-1] == lane.b[W-1]) && (addExt[W-1] != lane.a[W-1]);
	// differing signs, result took the sign of B
	assign subOvf = (lane.a[W-1] != lane.b[W-1]) && (subExt[W-1] != lane.a[W-1]);

	always_comb begin
		lane.claim = 1'b1;
		lane.res = '0;
		lane.flagsNext = lane.flagsIn;	// unnamed flags hold

		case (lane.op)
			cpuAluPkg::opAdd, cpuAluPkg::opAdc: begin
				lane.res = addExt[W-1:0];
				lane.flagsNext.c = addExt[W];
				lane.flagsNext.z = (addExt[W-1:0] == '0);
				lane.flagsNext.s = addExt[W-1];
				lane.flagsNext.v = addOvf;
			end
			cpuAluPkg::opSub, cpuAluPkg::opSbb: begin
				lane.res = subExt[W-1:0];
				lane.flagsNext.c = subExt[W];
				lane.flagsNext.z = (subExt[W-1:0] == '0);
				lane.flagsNext.s = subExt[W-1];
				lane.flagsNext.v = subOvf;
			end
			cpuAluPkg::opCmp: begin
				lane.res = lane.a;	// V untouched
				lane.flagsNext.c = subExt[W];
				lane.flagsNext.z = (subExt[W-1:0] == '0);
				lane.flagsNext.s = subExt[W-1];
			end
			cpuAluPkg::opMul: begin
				lane.res = mulLo;
				lane.flagsNext.c = 1'b0;
				lane.flagsNext.z = (mulLo == '0);
				lane.flagsNext.s = mulLo[W-1];
			end
			cpuAluPkg::opMulu: begin
				lane.res = mulHi;
				lane.flagsNext.c = 1'b0;
				lane.flagsNext.z = (mulHi == '0);
				lane.flagsNext.s = mulHi[W-1];
			end
			default: begin
				lane.claim = 1'b0;	// not ours
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/aluLaneIf.sv
// lane between the commit block and one execution unit
// unit side computes, commit side supplies operands and current flags

`default_nettype none

interface aluLaneIf;

	cpuAluPkg::aluDataT a;	// operand A
	cpuAluPkg::aluDataT b;	// operand B
	cpuAluPkg::aluOpE op;
	cpuAluPkg::aluFlagsT flagsIn;	// registered flags

	logic claim;	// op belongs to this unit
	cpuAluPkg::aluDataT res;
	cpuAluPkg::aluFlagsT flagsNext;

	modport unit (
		input  a, b, op, flagsIn,
		output claim, res, flagsNext
	);

	modport commit (
		output a, b, op, flagsIn,
		input  claim, res, flagsNext
	);

endinterface

`default_nettype wire

//--- src/cpuAluPkg.sv
// shared ALU types
// data word, opcode enum and the C/Z/S/V flag struct

`include "cpuAlu_consts.svh"

`default_nettype none

package cpuAluPkg;

	typedef logic [`ALU_BITS-1:0] aluDataT;	// operands and results

	// codes 10, 11, 14, 15, 21, 22 and 31 are reserved
	typedef enum logic [`ALU_OP_BITS-1:0] {
		opMove         = 0,
		opAdd          = 1,
		opAdc          = 2,
		opSub          = 3,
		opSbb          = 4,
		opAnd          = 5,
		opOr           = 6,
		opXor          = 7,
		opMul          = 8,
		opMulu         = 9,
		opCmp          = 12,
		opTest         = 13,
		opAsr          = 16,
		opLsr          = 17,
		opLsl          = 18,
		opRolc         = 19,	// left through carry
		opRorc         = 20,	// right through carry
		opClc          = 23,
		opStc          = 24,
		opClz          = 25,
		opStz          = 26,
		opCls          = 27,
		opSts          = 28,
		opStoreFlags   = 29,	// S, C, Z into bits 2..0
		opRestoreFlags = 30	// Z, C, S from bits 0..2
	} aluOpE;

	typedef struct packed {
		logic c;	// carry or borrow
		logic z;	// zero
		logic s;	// sign
		logic v;	// signed overflow
	} aluFlagsT;

endpackage

`default_nettype wire

//--- src/cpuAlu_consts.svh
// ALU width constants
// data word width, opcode field width and the full product width

`ifndef CPU_ALU_CONSTS_SVH
`define CPU_ALU_CONSTS_SVH

// one machine word
`define ALU_BITS 16

// opcode field of the instruction word
`define ALU_OP_BITS 5

// mul and mulu both come from one double-width product
`define ALU_PROD_BITS (2 * `ALU_BITS)

`endif
